// File: armPkg.sv
package armPkg;

  // Data-processing opcodes at their ARM encoding in bits 24:21
  typedef enum logic [3:0] {
    aluAnd = 4'b0000,
    aluEor = 4'b0001,
    aluSub = 4'b0010,
    aluRsb = 4'b0011,
    aluAdd = 4'b0100,
    aluOrr = 4'b1100,
    aluMov = 4'b1101,
    aluBic = 4'b1110,
    aluMvn = 4'b1111
  } aluOpT;

  // Shift type field in bits 6:5 of a register operand
  typedef enum logic [1:0] {
    lsl = 2'b00,
    lsr = 2'b01,
    asr = 2'b10,
    ror = 2'b11
  } shiftT;

  // Instruction class as given by bits 27:26
  typedef enum logic [1:0] {
    dataProc = 2'b00,
    memory   = 2'b01,
    branch   = 2'b10,
    undef    = 2'b11
  } instrClassT;

  typedef logic [3:0] regAddrT;

  // Control word carried down the pipe
  // All zero is a bubble
  typedef struct packed {
    logic    regWrite;
    logic    memWrite;
    logic    memToReg;
    logic    isBranch;
    logic    aluSrcImm;
    logic    addOffset;
    aluOpT   aluOp;
    shiftT   shiftType;
    logic [4:0] shiftAmt;
    logic [3:0] rotImm;
  } ctrlT;

endpackage

// File: pipePkg.sv
package pipePkg;

  // Fetch, Decode, Execute, Memory and Writeback
  localparam int numStages = 5;

  // Source of an Execute-stage operand
  typedef enum logic [1:0] {
    // Register file value read in Decode
    fwdNone = 2'b00,
    // ALU result sitting in Memory
    fwdMem  = 2'b01,
    // Final result sitting in Writeback
    fwdWb   = 2'b10
  } fwdSelT;

endpackage

// File: hazardIf.sv
`timescale 1ns/1ps

interface hazardIf (
  input logic clk,
  input logic rstN
);

  // Sources of the instructions in Decode and Execute
  armPkg::regAddrT ra1D, ra2D;
  armPkg::regAddrT ra1E, ra2E;
  // Destinations further down the pipe
  armPkg::regAddrT wa3E, wa3M, wa3W;
  logic regWriteM, regWriteW;
  logic memToRegE;
  logic branchTakenE;
  // Steering back into the pipe
  logic stallF, stallD, flushD, flushE;
  pipePkg::fwdSelT forwardAE, forwardBE;

  modport datapath (
    output ra1D, ra2D, ra1E, ra2E, wa3E, wa3M, wa3W,
    output regWriteM, regWriteW, memToRegE, branchTakenE,
    input  stallF, stallD, flushD, flushE, forwardAE, forwardBE
  );

  modport hazard (
    input  clk, rstN,
    input  ra1D, ra2D, ra1E, ra2E, wa3E, wa3M, wa3W,
    input  regWriteM, regWriteW, memToRegE, branchTakenE,
    output stallF, stallD, flushD, flushE, forwardAE, forwardBE
  );

endinterface

// File: regFile.sv
`timescale 1ns/1ps

module regFile #(
  parameter int dataWidth = 32
) (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 we,
  input  armPkg::regAddrT      ra1,
  input  armPkg::regAddrT      ra2,
  input  armPkg::regAddrT      wa3,
  input  logic [dataWidth-1:0] wd3,
  input  logic [dataWidth-1:0] pcPlus8,
  output logic [dataWidth-1:0] rd1,
  output logic [dataWidth-1:0] rd2
);

  // R0 to R14 only
  // R15 is the PC and is held in the datapath
  logic [dataWidth-1:0] regs [0:14];

  // R15 reads as PC plus 8
  // A write in this cycle is visible at once
  function automatic logic [dataWidth-1:0] readPort(input armPkg::regAddrT ra);
    if (ra == 4'hf) begin
      return pcPlus8;
    end else if (we && ra == wa3) begin
      return wd3;
    end
    return regs[ra];
  endfunction

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < 15; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa3 != 4'hf) begin
      regs[wa3] <= wd3;
    end
  end

  always_comb begin
    rd1 = readPort(ra1);
    rd2 = readPort(ra2);
  end

  // No instruction of the subset writes the PC through Writeback
  assert property (@(posedge clk) disable iff (!rstN) !(we && wa3 == 4'hf));

endmodule

// File: aluShifter.sv
`timescale 1ns/1ps

module aluShifter #(
  parameter int dataWidth = 32
) (
  input  logic [dataWidth-1:0] srcA,
  input  logic [dataWidth-1:0] srcB,
  input  logic                 useImm,
  input  logic [3:0]           rotImm,
  input  armPkg::shiftT        shiftType,
  input  logic [4:0]           shiftAmt,
  input  armPkg::aluOpT        aluOp,
  output logic [dataWidth-1:0] result
);

  logic [dataWidth-1:0] shifted;
  logic [dataWidth-1:0] opB;

  // Rotate right by amt
  // Amount 0 returns the value unchanged
  function automatic logic [dataWidth-1:0] rotr(input logic [dataWidth-1:0] val,
                                                input int unsigned amt);
    return (val >> amt) | (val << (dataWidth - amt));
  endfunction

  // ========================================
  // Operand B
  // ========================================

  // Barrel shifter for the register operand
  always_comb begin
    case (shiftType)
      armPkg::lsl: shifted = srcB << shiftAmt;
      // Amount 0 on LSR means a shift by the full width
      armPkg::lsr: shifted = (shiftAmt == 5'd0) ? '0 : srcB >> shiftAmt;
      // Same for ASR, which leaves only sign bits
      armPkg::asr: begin
        if (shiftAmt == 5'd0) begin
          shifted = {dataWidth{srcB[dataWidth-1]}};
        end else begin
          shifted = $signed(srcB) >>> shiftAmt;
        end
      end
      // No RRX here
      armPkg::ror: shifted = rotr(srcB, shiftAmt);
      default:     shifted = srcB;
    endcase
  end

  // Immediates rotate right by twice the 4-bit field
  assign opB = useImm ? rotr(srcB, {rotImm, 1'b0}) : shifted;

  // ========================================
  // ALU
  // ========================================

  always_comb begin
    case (aluOp)
      armPkg::aluAnd: result = srcA & opB;
      armPkg::aluEor: result = srcA ^ opB;
      armPkg::aluSub: result = srcA - opB;
      armPkg::aluRsb: result = opB - srcA;
      armPkg::aluAdd: result = srcA + opB;
      armPkg::aluOrr: result = srcA | opB;
      // MOV and MVN take no first operand
      armPkg::aluMov: result = opB;
      armPkg::aluBic: result = srcA & ~opB;
      armPkg::aluMvn: result = ~opB;
      default:        result = '0;
    endcase
  end

endmodule

// File: ctrlDecoder.sv
`timescale 1ns/1ps

module ctrlDecoder (
  input  logic [31:0]  instrD,
  output armPkg::ctrlT ctrlD
);

  armPkg::instrClassT cls;
  logic opOk;

  assign cls = armPkg::instrClassT'(instrD[27:26]);

  // Only nine of the sixteen opcodes are supported
  always_comb begin
    case (instrD[24:21])
      armPkg::aluAnd, armPkg::aluEor, armPkg::aluSub, armPkg::aluRsb,
      armPkg::aluAdd, armPkg::aluOrr, armPkg::aluMov, armPkg::aluBic,
      armPkg::aluMvn: opOk = 1'b1;
      default:        opOk = 1'b0;
    endcase
  end

  always_comb begin
    // Anything not matched below stays a bubble
    ctrlD = '0;
    case (cls)
      armPkg::dataProc: begin
        // Register-shifted-register forms are not supported
        if (opOk && (instrD[25] || !instrD[4])) begin
          ctrlD.regWrite  = 1'b1;
          ctrlD.aluOp     = armPkg::aluOpT'(instrD[24:21]);
          ctrlD.aluSrcImm = instrD[25];
          if (instrD[25]) begin
            ctrlD.rotImm = instrD[11:8];
          end else begin
            ctrlD.shiftType = armPkg::shiftT'(instrD[6:5]);
            ctrlD.shiftAmt  = instrD[11:7];
          end
        end
      end
      armPkg::memory: begin
        // Immediate offset only with pre-indexed word access and no writeback
        if (!instrD[25] && instrD[24] && !instrD[22] && !instrD[21]) begin
          ctrlD.addOffset = instrD[23];
          ctrlD.aluOp     = ctrlD.addOffset ? armPkg::aluAdd : armPkg::aluSub;
          ctrlD.aluSrcImm = 1'b1;
          // L bit picks load or store
          ctrlD.memToReg  = instrD[20];
          ctrlD.regWrite  = instrD[20];
          ctrlD.memWrite  = !instrD[20];
        end
      end
      armPkg::branch: begin
        // B only with its target computed as PC plus 8 plus offset in the ALU
        if (instrD[25] && !instrD[24]) begin
          ctrlD.isBranch  = 1'b1;
          ctrlD.aluOp     = armPkg::aluAdd;
          ctrlD.aluSrcImm = 1'b1;
        end
      end
      armPkg::undef: ctrlD = '0;
    endcase
  end

endmodule

// File: hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
  hazardIf.hazard hz
);

  logic ldUse;

  // Youngest producer wins
  // PC reads are never forwarded
  function automatic pipePkg::fwdSelT pickFwd(input armPkg::regAddrT src,
                                              input armPkg::regAddrT wa3M,
                                              input logic            regWriteM,
                                              input armPkg::regAddrT wa3W,
                                              input logic            regWriteW);
    if (src == 4'hf) begin
      return pipePkg::fwdNone;
    end else if (regWriteM && src == wa3M) begin
      return pipePkg::fwdMem;
    end else if (regWriteW && src == wa3W) begin
      return pipePkg::fwdWb;
    end
    return pipePkg::fwdNone;
  endfunction

  always_comb begin
    hz.forwardAE = pickFwd(hz.ra1E, hz.wa3M, hz.regWriteM, hz.wa3W, hz.regWriteW);
    hz.forwardBE = pickFwd(hz.ra2E, hz.wa3M, hz.regWriteM, hz.wa3W, hz.regWriteW);
  end

  // Load in Execute feeding the instruction in Decode
  assign ldUse = hz.memToRegE && (hz.wa3E == hz.ra1D || hz.wa3E == hz.ra2D);

  // Hold Fetch and Decode one cycle and send a bubble to Execute
  assign hz.stallF = ldUse;
  assign hz.stallD = ldUse;
  // Taken branch kills the two younger instructions
  assign hz.flushD = hz.branchTakenE;
  assign hz.flushE = ldUse || hz.branchTakenE;

  // A branch in Execute never carries a load, so the two cannot meet
  assert property (@(posedge hz.clk) disable iff (!hz.rstN)
    !(hz.stallD && hz.branchTakenE));

endmodule

// File: datapath.sv
`timescale 1ns/1ps

module datapath #(
  parameter int dataWidth = 32
) (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic [31:0]          instrF,
  output logic [dataWidth-1:0] pcF,
  output logic [31:0]          instrD,
  input  armPkg::ctrlT         ctrlD,
  output logic [dataWidth-1:0] dataAddrM,
  output logic [dataWidth-1:0] writeDataM,
  output logic                 memWriteM,
  input  logic [dataWidth-1:0] readDataM,
  hazardIf.datapath            hz
);

  // Enable and clear per register bank
  // Index 1 is Decode and the top index is Writeback
  logic [pipePkg::numStages-1:1] bankEn, bankClr;
  logic validD;
  armPkg::ctrlT ctrlE, ctrlM, ctrlW;
  logic [dataWidth-1:0] pcPlus4F, pcNextF, pcPlus8D, immD, rd1D, rd2D;
  logic [dataWidth-1:0] rd1E, rd2E, immE, pcPlus8E, fwdAE, srcAE, srcBE;
  logic [dataWidth-1:0] writeDataE, aluResultE;
  logic [dataWidth-1:0] aluOutM, aluOutW, readDataW, resultW;

  // No back-pressure from memory, so Memory and Writeback always advance
  assign bankEn  = {1'b1, 1'b1, 1'b1, ~hz.stallD};
  assign bankClr = {1'b0, 1'b0, hz.flushE, hz.flushD};

  // Selects a forwarded value for an Execute operand
  function automatic logic [dataWidth-1:0] fwdMux(input pipePkg::fwdSelT      sel,
                                                  input logic [dataWidth-1:0] fromReg);
    case (sel)
      pipePkg::fwdMem: return aluOutM;
      pipePkg::fwdWb:  return resultW;
      default:         return fromReg;
    endcase
  endfunction

  // ========================================
  // Fetch
  // ========================================
  assign pcPlus4F = pcF + dataWidth'(4);
  assign pcNextF  = hz.branchTakenE ? aluResultE : pcPlus4F;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pcF <= '0;
    end else if (!hz.stallF) begin
      pcF <= pcNextF;
    end
  end

  // ========================================
  // Decode
  // ========================================
  // validD marks a real instruction in instrD
  always_ff @(posedge clk) begin
    if (!rstN || bankClr[1]) begin
      validD <= 1'b0;
    end else if (bankEn[1]) begin
      validD <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (bankEn[1]) begin
      instrD <= instrF;
    end
  end

  // PC already runs two words ahead of Decode
  assign pcPlus8D = pcPlus4F;
  assign hz.ra1D  = instrD[19:16];
  // STR reads its data register from the Rd field
  assign hz.ra2D  = ctrlD.memWrite ? instrD[15:12] : instrD[3:0];

  always_comb begin
    if (ctrlD.isBranch) begin
      immD = {{(dataWidth-26){instrD[23]}}, instrD[23:0], 2'b00};
    end else if (instrD[26]) begin
      // Bit 26 set means a load or store offset
      immD = {{(dataWidth-12){1'b0}}, instrD[11:0]};
    end else begin
      // Rotation field goes in the control word
      immD = {{(dataWidth-8){1'b0}}, instrD[7:0]};
    end
  end

  regFile #(.dataWidth(dataWidth)) regFile_i (
    .clk    (clk),
    .rstN   (rstN),
    .we     (ctrlW.regWrite),
    .ra1    (hz.ra1D),
    .ra2    (hz.ra2D),
    .wa3    (hz.wa3W),
    .wd3    (resultW),
    .pcPlus8(pcPlus8D),
    .rd1    (rd1D),
    .rd2    (rd2D)
  );

  // ========================================
  // Execute
  // ========================================
  always_ff @(posedge clk) begin
    if (!rstN || bankClr[2]) begin
      ctrlE <= '0;
    end else if (bankEn[2]) begin
      ctrlE <= validD ? ctrlD : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (bankEn[2]) begin
      rd1E     <= rd1D;
      rd2E     <= rd2D;
      immE     <= immD;
      pcPlus8E <= pcPlus8D;
      hz.ra1E  <= hz.ra1D;
      hz.ra2E  <= hz.ra2D;
      hz.wa3E  <= instrD[15:12];
    end
  end

  always_comb begin
    fwdAE      = fwdMux(hz.forwardAE, rd1E);
    writeDataE = fwdMux(hz.forwardBE, rd2E);
  end

  // Branch target is the branch's own PC plus 8 plus the offset
  assign srcAE = ctrlE.isBranch ? pcPlus8E : fwdAE;
  assign srcBE = ctrlE.aluSrcImm ? immE : writeDataE;

  aluShifter #(.dataWidth(dataWidth)) aluShifter_i (
    .srcA     (srcAE),
    .srcB     (srcBE),
    .useImm   (ctrlE.aluSrcImm),
    .rotImm   (ctrlE.rotImm),
    .shiftType(ctrlE.shiftType),
    .shiftAmt (ctrlE.shiftAmt),
    .aluOp    (ctrlE.aluOp),
    .result   (aluResultE)
  );

  assign hz.memToRegE    = ctrlE.memToReg;
  assign hz.branchTakenE = ctrlE.isBranch;

  // ========================================
  // Memory
  // ========================================
  always_ff @(posedge clk) begin
    if (!rstN || bankClr[3]) begin
      ctrlM <= '0;
    end else if (bankEn[3]) begin
      ctrlM <= ctrlE;
    end
  end

  always_ff @(posedge clk) begin
    if (bankEn[3]) begin
      aluOutM    <= aluResultE;
      writeDataM <= writeDataE;
      hz.wa3M    <= hz.wa3E;
    end
  end

  assign dataAddrM    = aluOutM;
  assign memWriteM    = ctrlM.memWrite;
  assign hz.regWriteM = ctrlM.regWrite;

  // ========================================
  // Writeback
  // ========================================
  always_ff @(posedge clk) begin
    if (!rstN || bankClr[4]) begin
      ctrlW <= '0;
    end else if (bankEn[4]) begin
      ctrlW <= ctrlM;
    end
  end

  always_ff @(posedge clk) begin
    if (bankEn[4]) begin
      aluOutW   <= aluOutM;
      readDataW <= readDataM;
      hz.wa3W   <= hz.wa3M;
    end
  end

  assign resultW      = ctrlW.memToReg ? readDataW : aluOutW;
  assign hz.regWriteW = ctrlW.regWrite;

  // A store never also claims a load writeback
  assert property (@(posedge clk) disable iff (!rstN)
    $rose(memWriteM) |-> !(ctrlM.regWrite && ctrlM.memToReg));

  // Every supported encoding sets some control bit
  // An empty control word in a live slot is an undefined instruction
  assert property (@(posedge clk) disable iff (!rstN)
    validD && !hz.flushE |-> ctrlD != '0);

endmodule

// File: pipeCore.sv
`timescale 1ns/1ps

module pipeCore #(
  parameter int dataWidth = 32
) (
  input  logic                 clk,
  input  logic                 rstN,
  output logic [dataWidth-1:0] pcF,
  input  logic [31:0]          instrF,
  output logic [dataWidth-1:0] dataAddrM,
  output logic [dataWidth-1:0] writeDataM,
  output logic                 memWriteM,
  input  logic [dataWidth-1:0] readDataM
);

  logic [31:0]  instrD;
  armPkg::ctrlT ctrlD;

  // Stall, flush and forwarding bundle
  hazardIf hz (
    .clk (clk),
    .rstN(rstN)
  );

  ctrlDecoder ctrlDecoder_i (
    .instrD(instrD),
    .ctrlD (ctrlD)
  );

  datapath #(.dataWidth(dataWidth)) datapath_i (
    .clk       (clk),
    .rstN      (rstN),
    .instrF    (instrF),
    .pcF       (pcF),
    .instrD    (instrD),
    .ctrlD     (ctrlD),
    .dataAddrM (dataAddrM),
    .writeDataM(writeDataM),
    .memWriteM (memWriteM),
    .readDataM (readDataM),
    .hz        (hz)
  );

  hazardUnit hazardUnit_i (
    .hz(hz)
  );

endmodule

// File: tbClock.sv
`timescale 1ns/1ps

module tbClock #(
  parameter int halfPeriod = 2
) (
  output logic clk
);

  // Free-running clock with a 4 ns period
  initial begin
    clk = 1'b0;
  end

  always #(halfPeriod) clk = ~clk;

endmodule

// File: tbPipeCore.sv
`timescale 1ns/1ps

module tbPipeCore;

  // ARM opcode field values in bits 24:21
  localparam logic [3:0] opAnd = 4'h0, opEor = 4'h1, opSub = 4'h2, opRsb = 4'h3;
  localparam logic [3:0] opAdd = 4'h4, opOrr = 4'hc, opMov = 4'hd, opBic = 4'he;
  localparam logic [3:0] opMvn = 4'hf;
  // B to itself ends every program
  localparam logic [31:0] selfLoop = 32'heaff_fffe;

  logic clk, rstN;
  logic [31:0] pcF, instrF, dataAddrM, writeDataM, readDataM;
  logic memWriteM;

  logic [31:0] rom [0:255];
  logic [31:0] dmem [0:255];
  logic [31:0] refMem [0:255];
  logic [31:0] prog [$];
  logic [31:0] expAddr [$];
  logic [31:0] expData [$];
  logic [3:0] opList [0:8] = '{opAnd, opEor, opSub, opRsb, opAdd, opOrr, opMov, opBic, opMvn};
  integer seed = 32'hf8e7_c6aa;
  int errCount = 0;
  int testErrs = 0;
  int testsRun = 0;
  int slot;
  time deadline = 64'd1_000_000;

  tbClock clkGen_i (.clk(clk));

  pipeCore #(.dataWidth(32)) pipeCore_i (
    .clk       (clk),
    .rstN      (rstN),
    .pcF       (pcF),
    .instrF    (instrF),
    .dataAddrM (dataAddrM),
    .writeDataM(writeDataM),
    .memWriteM (memWriteM),
    .readDataM (readDataM)
  );

  // ========================================
  // Memories
  // ========================================
  // Start-up data word as a function of the whole word index
  function automatic logic [31:0] fillWord(input int i);
    logic [7:0] a;
    a = i[7:0];
    return {a, ~a, a ^ 8'h5a, 8'hc3};
  endfunction

  assign instrF    = rom[pcF[9:2]];
  assign readDataM = dmem[dataAddrM[9:2]];

  // Reset reloads the data memory
  always @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < 256; i++) begin
        dmem[i] <= fillWord(i);
      end
    end else if (memWriteM) begin
      dmem[dataAddrM[9:2]] <= writeDataM;
    end
  end

  // ========================================
  // Instruction encoders
  // ========================================
  function automatic logic [31:0] dpImm(input logic [3:0] op, input logic [3:0] rd,
                                        input logic [3:0] rn, input logic [3:0] rot,
                                        input logic [7:0] imm);
    return {4'he, 2'b00, 1'b1, op, 1'b0, rn, rd, rot, imm};
  endfunction

  function automatic logic [31:0] dpReg(input logic [3:0] op, input logic [3:0] rd,
                                        input logic [3:0] rn, input logic [3:0] rm,
                                        input logic [1:0] sh, input logic [4:0] amt);
    return {4'he, 2'b00, 1'b0, op, 1'b0, rn, rd, amt, sh, 1'b0, rm};
  endfunction

  // Pre-indexed word access without writeback
  function automatic logic [31:0] memOp(input logic load, input logic up,
                                        input logic [3:0] rd, input logic [3:0] rn,
                                        input logic [11:0] off);
    return {4'he, 2'b01, 1'b0, 1'b1, up, 1'b0, 1'b0, load, rn, rd, off};
  endfunction

  // Offset counted in words from the branch's PC plus 8
  function automatic logic [31:0] br(input int off);
    logic [31:0] o;
    o = off;
    return {4'he, 3'b101, 1'b0, o[23:0]};
  endfunction

  task automatic put(input logic [31:0] ins);
    prog.push_back(ins);
  endtask

  // Instruction followed by a store of its Rd to the next slot
  task automatic putStore(input logic [31:0] ins);
    prog.push_back(ins);
    prog.push_back(memOp(1'b0, 1'b1, ins[15:12], 4'd0, 12'(slot * 4)));
    slot++;
  endtask

  // ========================================
  // Reference interpreter
  // ========================================
  function automatic logic [31:0] rotRight(input logic [31:0] v, input int n);
    if (n == 0) begin
      return v;
    end
    return (v >> n) | (v << (32 - n));
  endfunction

  // Register operand shift where amount 0 on LSR and ASR means 32
  function automatic logic [31:0] shiftOp(input logic [31:0] v, input logic [1:0] t,
                                          input int n);
    case (t)
      2'd0: return v << n;
      2'd1: return (n == 0) ? 32'd0 : v >> n;
      2'd2: return (n == 0) ? {32{v[31]}} : 32'($signed(v) >>> n);
      default: return rotRight(v, n);
    endcase
  endfunction

  // Runs the ROM one instruction at a time and lists the stores in order
  function automatic void runReference();
    logic [31:0] r [0:15];
    logic [31:0] pc, ins, a, b, res, addr;
    for (int i = 0; i < 16; i++) begin
      r[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      refMem[i] = fillWord(i);
    end
    pc = '0;
    for (int steps = 0; steps < 4096; steps++) begin
      ins = rom[pc[9:2]];
      r[15] = pc + 8;
      if (ins[27:25] == 3'b101) begin
        if (ins == selfLoop) begin
          break;
        end
        pc = pc + 8 + {{6{ins[23]}}, ins[23:0], 2'b00};
        continue;
      end
      a = r[ins[19:16]];
      if (ins[27:26] == 2'b01) begin
        addr = ins[23] ? a + ins[11:0] : a - ins[11:0];
        if (ins[20]) begin
          r[ins[15:12]] = refMem[addr[9:2]];
        end else begin
          refMem[addr[9:2]] = r[ins[15:12]];
          expAddr.push_back(addr);
          expData.push_back(r[ins[15:12]]);
        end
      end else begin
        if (ins[25]) begin
          b = rotRight({24'd0, ins[7:0]}, 2 * ins[11:8]);
        end else begin
          b = shiftOp(r[ins[3:0]], ins[6:5], ins[11:7]);
        end
        case (ins[24:21])
          opAnd: res = a & b;
          opEor: res = a ^ b;
          opSub: res = a - b;
          opRsb: res = b - a;
          opAdd: res = a + b;
          opOrr: res = a | b;
          opMov: res = b;
          opBic: res = a & ~b;
          default: res = ~b;
        endcase
        r[ins[15:12]] = res;
      end
      pc = pc + 4;
    end
  endfunction

  // ========================================
  // Store checker and watchdog
  // ========================================
  always @(posedge clk) begin
    if (rstN && memWriteM) begin
      if (expAddr.size() == 0) begin
        $display("t=%0t: store to %h after the last expected store", $time, dataAddrM);
        testErrs++;
      end else begin
        assert (dataAddrM == expAddr[0]) else begin
          $display("FAIL t=%0t dataAddrM expected %h got %h", $time, expAddr[0], dataAddrM);
          testErrs++;
        end
        assert (writeDataM == expData[0]) else begin
          $display("FAIL t=%0t writeDataM expected %h got %h", $time, expData[0], writeDataM);
          testErrs++;
        end
        void'(expAddr.pop_front());
        void'(expData.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    if ($time > deadline) begin
      $display("Timeout: the program never made all of its expected stores");
      $display("Test failed");
      $finish;
    end
  end

  // Loads the program, resets the core and waits for every store
  task automatic runTest(input string name);
    int n;
    @(posedge clk);
    rstN <= 1'b0;
    @(posedge clk);
    for (int i = 0; i < 256; i++) begin
      rom[i] = (i < prog.size()) ? prog[i] : selfLoop;
    end
    expAddr.delete();
    expData.delete();
    runReference();
    n = expAddr.size();
    repeat (2) @(posedge clk);
    // Fetch restarts from address 0 after reset
    @(negedge clk);
    assert (pcF == 32'd0) else begin
      $display("FAIL t=%0t pcF expected %h got %h", $time, 32'd0, pcF);
      testErrs++;
    end
    @(posedge clk);
    rstN <= 1'b1;
    deadline = $time + 64'((40 * prog.size() + 100) * 4);
    while (expAddr.size() != 0) begin
      @(posedge clk);
    end
    errCount += testErrs;
    testsRun++;
    $display("%s: %0d stores, %0d errors", name, n, testErrs);
    testErrs = 0;
    prog.delete();
    slot = 0;
  endtask

  // ========================================
  // Programs
  // ========================================
  initial begin
    rstN = 1'b0;
    slot = 0;
    for (int i = 0; i < 256; i++) begin
      rom[i] = selfLoop;
    end

    // Every opcode, rotated immediates and all four shifts
    put(dpImm(opMov, 1, 0, 0, 8'h5a));
    put(dpImm(opMov, 2, 0, 4, 8'hf0));
    put(dpImm(opMvn, 3, 0, 0, 8'h03));
    putStore(dpImm(opMov, 5, 0, 15, 8'h81));
    putStore(dpReg(opAnd, 4, 3, 2, 2'd0, 5'd3));
    putStore(dpReg(opEor, 4, 1, 3, 2'd1, 5'd1));
    putStore(dpReg(opSub, 4, 3, 2, 2'd2, 5'd4));
    putStore(dpReg(opAdd, 4, 1, 2, 2'd3, 5'd7));
    putStore(dpImm(opRsb, 4, 1, 0, 8'h7f));
    putStore(dpImm(opOrr, 4, 1, 1, 8'hff));
    putStore(dpReg(opBic, 4, 3, 1, 2'd0, 5'd0));
    putStore(dpReg(opMov, 4, 0, 2, 2'd2, 5'd0));
    putStore(dpReg(opMvn, 4, 0, 1, 2'd1, 5'd0));
    putStore(dpReg(opMov, 4, 0, 3, 2'd3, 5'd0));
    putStore(dpImm(opEor, 4, 3, 9, 8'hc3));
    put(selfLoop);
    runTest("data processing");

    // Dependent chains through the Memory and Writeback paths
    put(dpImm(opMov, 1, 0, 0, 8'd1));
    put(dpReg(opAdd, 2, 1, 1, 2'd0, 5'd0));
    put(dpReg(opAdd, 3, 2, 1, 2'd0, 5'd0));
    put(dpReg(opAdd, 4, 3, 2, 2'd0, 5'd1));
    putStore(dpReg(opSub, 5, 4, 3, 2'd0, 5'd0));
    put(memOp(1'b0, 1'b1, 4, 0, 12'h40));
    put(dpReg(opOrr, 6, 5, 2, 2'd3, 5'd1));
    put(dpReg(opEor, 7, 6, 6, 2'd0, 5'd0));
    putStore(dpReg(opRsb, 1, 6, 5, 2'd0, 5'd2));
    put(memOp(1'b0, 1'b1, 6, 0, 12'h44));
    put(memOp(1'b0, 1'b1, 7, 0, 12'h48));
    put(selfLoop);
    runTest("forwarding");

    // Loaded values used by the very next instruction
    put(memOp(1'b1, 1'b1, 1, 0, 12'h008));
    put(dpImm(opAdd, 2, 1, 0, 8'd1));
    put(memOp(1'b0, 1'b1, 2, 0, 12'h040));
    put(memOp(1'b1, 1'b1, 3, 0, 12'h00c));
    put(memOp(1'b0, 1'b1, 3, 0, 12'h044));
    put(memOp(1'b1, 1'b1, 5, 0, 12'h010));
    put(dpReg(opEor, 6, 5, 1, 2'd0, 5'd2));
    put(memOp(1'b0, 1'b1, 6, 0, 12'h048));
    put(selfLoop);
    runTest("load-use");

    // Forward and backward branches whose flushed slots would store early
    put(dpImm(opMov, 1, 0, 0, 8'h11));
    put(dpImm(opMov, 7, 0, 0, 8'hee));
    put(br(2));
    put(memOp(1'b0, 1'b1, 7, 0, 12'h0f0));
    put(memOp(1'b0, 1'b1, 7, 0, 12'h0f4));
    put(memOp(1'b0, 1'b1, 7, 0, 12'h0f8));
    put(memOp(1'b0, 1'b1, 1, 0, 12'h080));
    put(br(3));
    put(dpImm(opMov, 1, 0, 0, 8'h99));
    put(memOp(1'b0, 1'b1, 1, 0, 12'h084));
    put(br(3));
    put(memOp(1'b0, 1'b1, 7, 0, 12'h0f0));
    put(dpImm(opAdd, 1, 1, 0, 8'h20));
    put(br(-6));
    put(memOp(1'b0, 1'b1, 7, 0, 12'h0f4));
    put(memOp(1'b0, 1'b1, 1, 0, 12'h088));
    put(selfLoop);
    runTest("branches");

    // Added and subtracted offsets and R15 as an operand
    put(dpImm(opMov, 1, 0, 12, 8'h01));
    put(memOp(1'b0, 1'b1, 1, 1, 12'h020));
    put(memOp(1'b1, 1'b0, 2, 1, 12'h020));
    put(memOp(1'b0, 1'b1, 2, 0, 12'h010));
    put(memOp(1'b0, 1'b0, 2, 1, 12'h040));
    put(memOp(1'b1, 1'b1, 3, 1, 12'h020));
    put(memOp(1'b0, 1'b1, 3, 1, 12'h044));
    put(dpImm(opAdd, 4, 15, 0, 8'd0));
    put(memOp(1'b0, 1'b1, 4, 0, 12'h014));
    put(memOp(1'b0, 1'b1, 15, 0, 12'h018));
    put(memOp(1'b1, 1'b1, 5, 15, 12'h100));
    put(memOp(1'b0, 1'b1, 5, 0, 12'h01c));
    put(dpReg(opMov, 6, 0, 15, 2'd0, 5'd0));
    put(memOp(1'b0, 1'b1, 6, 0, 12'h020));
    put(selfLoop);
    runTest("address arithmetic");

    // Seeded random data processing with every result stored
    for (int k = 1; k < 8; k++) begin
      put(dpImm(opMov, 4'(k), 0, 4'($unsigned($random(seed)) % 16),
                8'($unsigned($random(seed)))));
    end
    for (int k = 0; k < 24; k++) begin
      if ($unsigned($random(seed)) % 2 == 0) begin
        putStore(dpImm(opList[$unsigned($random(seed)) % 9],
                       4'(1 + $unsigned($random(seed)) % 7),
                       4'(1 + $unsigned($random(seed)) % 7),
                       4'($unsigned($random(seed)) % 16),
                       8'($unsigned($random(seed)))));
      end else begin
        putStore(dpReg(opList[$unsigned($random(seed)) % 9],
                       4'(1 + $unsigned($random(seed)) % 7),
                       4'(1 + $unsigned($random(seed)) % 7),
                       4'(1 + $unsigned($random(seed)) % 7),
                       2'($unsigned($random(seed)) % 4),
                       5'($unsigned($random(seed)) % 32)));
      end
    end
    put(selfLoop);
    runTest("random mix");

    $display("%0d tests run, %0d errors", testsRun, errCount);
    if (errCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: list.f
armPkg.sv
pipePkg.sv
hazardIf.sv
regFile.sv
aluShifter.sv
ctrlDecoder.sv
hazardUnit.sv
datapath.sv
pipeCore.sv
tbClock.sv
tbPipeCore.sv

// File: run.sh
#!/bin/sh
# Compile and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tbPipeCore -f list.f -o simPipeCore
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

out=$(./obj_dir/simPipeCore)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1
